//--- sim/bus_stimulus.txt
# name op addr wb_n data expected   (hex, wb_n binary)
# op W write, R read and compare, S set switches; W to LED or hex checks the panel outputs
w_mem0    W 0000 00 1234 0000
w_mem1    W 0002 00 abcd 0000
w_mem7f   W 00fe 00 5a5a 0000
w_memtop  W 01fe 00 c3e1 0000
r_mem0    R 0000 11 0000 1234
r_mem1    R 0002 11 0000 abcd
r_mem7f   R 00fe 11 0000 5a5a
r_memtop  R 01fe 11 0000 c3e1
wl_mem1   W 0002 10 ff77 0000
rl_mem1   R 0002 11 0000 ab77
wh_mem1   W 0002 01 1199 0000
rh_mem1   R 0002 11 0000 1177
wh_mem0   W 0000 01 ee00 0000
rh_mem0   R 0000 11 0000 ee34
s_sw1     S 0000 11 02a5 0000
r_sw1     R fff8 11 0000 02a5
s_sw2     S 0000 11 035c 0000
w_swro    W fff8 00 ffff 0000
r_sw2     R fff8 11 0000 035c
w_led     W fffa 00 0155 0155
r_led     R fffa 11 0000 0155
w_ledhi   W fffa 01 fe00 0255
r_ledhi   R fffa 11 0000 0255
w_hex1    W fffc 00 1234 1234
w_hex2    W fffc 00 5678 5678
w_hex3    W fffc 00 9abc 9abc
w_hex4    W fffc 00 def0 def0
w_hexlo   W fffc 10 99ef deef
w_hexhi   W fffc 01 0f00 0fef
r_hex     R fffc 11 0000 0fef
w_unmap   W 0400 00 dead 0000
r_unmap   R 0400 11 0000 0000
r_alias   R 0000 11 0000 ee34
r_unmap2  R 8000 11 0000 0000

//--- vlog.f
common/t11_bus_pkg.sv
common/board_pkg.sv
common/bus_if.sv
design/reset_hold.sv
design/bus_cycle_fsm.sv
design/word_memory.sv
panel/panel_regs.sv
design/t11_board_target.sv
sim/tb_t11_board_target.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = tb_t11_board_target
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_t11_board_target.sv
// Bus target testbench
`timescale 1ns/10ps

module tb_t11_board_target;

   typedef logic [8*24-1:0] tname_t;                   // Test name as read from file

   localparam int timeout_cycles = 200;                // Longest wait in cycles
   localparam t11_bus_pkg::ad_word_t led_addr =
      board_pkg::panel_base + 16'(2 * board_pkg::reg_leds);
   localparam t11_bus_pkg::ad_word_t hex_addr =
      board_pkg::panel_base + 16'(2 * board_pkg::reg_hex);

   logic                            clk = 1'b0;
   logic                            rst_n;
   logic [board_pkg::led_width-1:0] sw;
   logic [board_pkg::led_width-1:0] led;
   logic [board_pkg::seg_width-1:0] hex0, hex1, hex2, hex3;
   logic                            ras_n;
   logic                            cas_n;
   t11_bus_pkg::byte_strobe_t       wb_n;
   t11_bus_pkg::ad_word_t           ad_in;
   t11_bus_pkg::ad_word_t           ad_out;
   logic                            ready;
   logic                            init;

   t11_board_target i_t11_board_target (.*);           // Default parameters

   always #10 clk = ~clk;                              // 20 ns period

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input t11_bus_pkg::ad_word_t exp,
                             input t11_bus_pkg::ad_word_t act);
      if (act !== exp)
         abort_run($sformatf("Mismatch %0s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_leds(input string name, input logic [board_pkg::led_width-1:0] exp,
                             input logic [board_pkg::led_width-1:0] act);
      if (act !== exp)
         abort_run($sformatf("Mismatch %0s leds: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("Mismatch %0s: expected %b, actual %b", name, exp, act));
   endtask

   // Active-low segments with g in bit 6 down to a in bit 0
   task automatic check_segments(input string name, input int digit, input logic [3:0] nib,
                                 input logic [board_pkg::seg_width-1:0] act);
      logic [board_pkg::seg_width-1:0] exp;
      case (nib)
         4'h0: exp = 7'b1000000;
         4'h1: exp = 7'b1111001;
         4'h2: exp = 7'b0100100;
         4'h3: exp = 7'b0110000;
         4'h4: exp = 7'b0011001;
         4'h5: exp = 7'b0010010;
         4'h6: exp = 7'b0000010;
         4'h7: exp = 7'b1111000;
         4'h8: exp = 7'b0000000;
         4'h9: exp = 7'b0010000;
         4'hA: exp = 7'b0001000;
         4'hB: exp = 7'b0000011;                       // Shown as b
         4'hC: exp = 7'b1000110;
         4'hD: exp = 7'b0100001;                       // Shown as d
         4'hE: exp = 7'b0000110;
         default: exp = 7'b0001110;
      endcase
      if (act !== exp)
         abort_run($sformatf("Mismatch %0s hex%0d: expected %b, actual %b",
                             name, digit, exp, act));
   endtask

   task automatic wait_ready(input logic level, input string name);
      int n;
      n = 0;
      @(negedge clk);                                  // Sample away from the edge
      while (ready !== level)
      begin
         if (n >= timeout_cycles)
            abort_run($sformatf("Timeout in %0s: ready never went to %0b", name, level));
         else
         begin
            n = n + 1;
            @(negedge clk);
         end
      end
   endtask

   task automatic end_cycle(input string name);
      @(posedge clk);
      ras_n <= 1'b1;                                   // Master saw ready
      cas_n <= 1'b1;
      wb_n  <= t11_bus_pkg::stb_read;
      ad_in <= '0;
      wait_ready(1'b0, name);
   endtask

   task automatic bus_write(input string name, input t11_bus_pkg::ad_word_t addr,
                            input t11_bus_pkg::byte_strobe_t wb,
                            input t11_bus_pkg::ad_word_t data);
      @(posedge clk);
      ad_in <= addr;                                   // RAS phase
      ras_n <= 1'b0;
      @(posedge clk);
      ad_in <= data;                                   // CAS phase carries data
      wb_n  <= wb;
      cas_n <= 1'b0;
      wait_ready(1'b1, name);
      end_cycle(name);
   endtask

   task automatic bus_read(input string name, input t11_bus_pkg::ad_word_t addr,
                           output t11_bus_pkg::ad_word_t rd);
      @(posedge clk);
      ad_in <= addr;
      ras_n <= 1'b0;
      @(posedge clk);
      cas_n <= 1'b0;                                   // Strobes stay at read
      wait_ready(1'b1, name);
      rd = ad_out;                                     // Valid while ready
      end_cycle(name);
   endtask

   task automatic play_line(input string name, input logic [7:0] op,
                            input t11_bus_pkg::ad_word_t addr,
                            input t11_bus_pkg::byte_strobe_t wb,
                            input t11_bus_pkg::ad_word_t data,
                            input t11_bus_pkg::ad_word_t exp);
      t11_bus_pkg::ad_word_t rd;
      case (op)
         "S":
         begin
            @(posedge clk);
            sw <= data[board_pkg::led_width-1:0];
         end
         "W":
         begin
            bus_write(name, addr, wb, data);
            if (addr == led_addr)
               check_leds(name, exp[board_pkg::led_width-1:0], led);
            else if (addr == hex_addr)
            begin
               check_segments(name, 0, exp[3:0], hex0);
               check_segments(name, 1, exp[7:4], hex1);
               check_segments(name, 2, exp[11:8], hex2);
               check_segments(name, 3, exp[15:12], hex3);
            end
         end
         "R":
         begin
            bus_read(name, addr, rd);
            check_word(name, exp, rd);
         end
         default:
            abort_run($sformatf("Unknown operation in stimulus line %0s", name));
      endcase
   endtask

   initial
   begin
      int                        fd;
      int                        n;
      int                        cnt;
      int                        ops;
      tname_t                    tok;
      logic [8*128-1:0]          rest;
      logic [7:0]                op;
      t11_bus_pkg::ad_word_t     addr;
      t11_bus_pkg::ad_word_t     data;
      t11_bus_pkg::ad_word_t     exp;
      t11_bus_pkg::byte_strobe_t wb;
      rst_n = 1'b0;
      sw    = '0;
      ras_n = 1'b1;
      cas_n = 1'b1;
      wb_n  = t11_bus_pkg::stb_read;
      ad_in = '0;
      ops   = 0;
      @(posedge clk);
      @(posedge clk);
      @(negedge clk);
      check_bit("reset_init", 1'b1, init);
      check_bit("reset_ready", 1'b0, ready);
      check_leds("reset_leds", '0, led);
      check_segments("reset_hex", 0, 4'h0, hex0);
      check_segments("reset_hex", 1, 4'h0, hex1);
      check_segments("reset_hex", 2, 4'h0, hex2);
      check_segments("reset_hex", 3, 4'h0, hex3);
      @(posedge clk);
      rst_n <= 1'b1;                                   // Third reset edge done
      cnt = 0;
      @(negedge clk);
      while (init !== 1'b0)
      begin
         if (cnt >= timeout_cycles)
            abort_run("Timeout: init never fell after reset release");
         else
         begin
            cnt = cnt + 1;
            @(negedge clk);
         end
      end
      if (cnt == 0)
         abort_run("init fell at once after reset release");
      fd = $fopen("sim/bus_stimulus.txt", "r");
      if (fd == 0)
         abort_run("Cannot open sim/bus_stimulus.txt");
      while (!$feof(fd))
      begin
         tok = '0;
         n = $fscanf(fd, "%s", tok);
         if (n == 1 && tok[7:0] == "#")
            n = $fgets(rest, fd);                      // Skip comment line
         else if (n == 1)
         begin
            n = $fscanf(fd, "%s %h %b %h %h", op, addr, wb, data, exp);
            if (n != 5)
               abort_run($sformatf("Malformed stimulus line %0s", tok));
            play_line($sformatf("%0s", tok), op, addr, wb, data, exp);
            ops = ops + 1;
         end
      end
      $fclose(fd);
      if (ops == 0)
         abort_run("Stimulus file held no operations");
      else
      begin
         $display("test passed");
         $finish;
      end
   end

endmodule

//--- design/t11_board_target.sv
// Board bus target top level
`timescale 1ns/10ps

module t11_board_target #(
   parameter int HOLD_CYCLES = 16,                     // Init stretch
   parameter int MEM_WORDS   = 256,                    // Memory depth
   parameter int WAIT_STATES = 1                       // Ready delay
)(
   input  logic                             clk,
   input  logic                             rst_n,     // Button reset
   input  logic [board_pkg::led_width-1:0]  sw,
   output logic [board_pkg::led_width-1:0]  led,
   output logic [board_pkg::seg_width-1:0]  hex0,
   output logic [board_pkg::seg_width-1:0]  hex1,
   output logic [board_pkg::seg_width-1:0]  hex2,
   output logic [board_pkg::seg_width-1:0]  hex3,
   input  logic                             ras_n,
   input  logic                             cas_n,
   input  t11_bus_pkg::byte_strobe_t        wb_n,
   input  t11_bus_pkg::ad_word_t            ad_in,
   output t11_bus_pkg::ad_word_t            ad_out,
   output logic                             ready,
   output logic                             init       // Target still starting
);

   bus_if acc ();                                      // Sequencer to targets

   reset_hold #(
      .HOLD_CYCLES(HOLD_CYCLES)
   ) i_reset_hold (
      .clk   (clk),
      .rst_n (rst_n),
      .init  (init)
   );

   bus_cycle_fsm #(
      .MEM_WORDS   (MEM_WORDS),
      .WAIT_STATES (WAIT_STATES)
   ) i_bus_cycle_fsm (
      .clk    (clk),
      .rst_n  (rst_n),
      .init   (init),
      .ras_n  (ras_n),
      .cas_n  (cas_n),
      .wb_n   (wb_n),
      .ad_in  (ad_in),
      .ad_out (ad_out),
      .ready  (ready),
      .acc    (acc.master)
   );

   word_memory #(
      .MEM_WORDS(MEM_WORDS)
   ) i_word_memory (
      .clk (clk),
      .acc (acc.target)
   );

   panel_regs i_panel_regs (
      .clk   (clk),
      .rst_n (rst_n),
      .sw    (sw),
      .led   (led),
      .hex0  (hex0),
      .hex1  (hex1),
      .hex2  (hex2),
      .hex3  (hex3),
      .acc   (acc.target)
   );

endmodule

//--- panel/panel_regs.sv
// Front panel registers
`timescale 1ns/10ps

module panel_regs (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [board_pkg::led_width-1:0]  sw,        // Switch inputs
   output logic [board_pkg::led_width-1:0]  led,       // LED drive
   output logic [board_pkg::seg_width-1:0]  hex0,      // Digit 0, lowest nibble
   output logic [board_pkg::seg_width-1:0]  hex1,
   output logic [board_pkg::seg_width-1:0]  hex2,
   output logic [board_pkg::seg_width-1:0]  hex3,      // Digit 3, highest nibble
   bus_if.target                            acc
);

   localparam int PAD = 16 - board_pkg::led_width;     // Zero bits on read

   logic [board_pkg::led_width-1:0] led_q;             // LED latch
   t11_bus_pkg::ad_word_t           hex_q;             // Display latch
   t11_bus_pkg::ad_union_t          wview;             // Write word by lanes
   board_pkg::panel_reg_t           offs;              // Register offset
   logic                            wr_en;             // Write aimed here

   // Active-low segments, bit 6 is g and bit 0 is a
   function automatic logic [board_pkg::seg_width-1:0] seg7(input logic [3:0] nib);
      case (nib)
         4'h0: return 7'h40;
         4'h1: return 7'h79;
         4'h2: return 7'h24;
         4'h3: return 7'h30;
         4'h4: return 7'h19;
         4'h5: return 7'h12;
         4'h6: return 7'h02;
         4'h7: return 7'h78;
         4'h8: return 7'h00;
         4'h9: return 7'h10;
         4'hA: return 7'h08;
         4'hB: return 7'h03;                           // Lower case b
         4'hC: return 7'h46;
         4'hD: return 7'h21;                           // Lower case d
         4'hE: return 7'h06;
         default: return 7'h0E;                        // F
      endcase
   endfunction

   assign wview = acc.wdata;
   assign offs  = acc.addr.a.word_idx[1:0];
   assign wr_en = acc.wr && (acc.sel == t11_bus_pkg::sel_panel);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         led_q <= '0;
         hex_q <= '0;
      end
      else if (wr_en)
      begin
         case (offs)
            board_pkg::reg_leds:
            begin
               if (!acc.strobe[t11_bus_pkg::lane_lo])
                  led_q[7:0] <= wview.d.lo;
               if (!acc.strobe[t11_bus_pkg::lane_hi])
                  led_q[board_pkg::led_width-1:8] <= wview.d.hi[board_pkg::led_width-9:0];
            end
            board_pkg::reg_hex:
            begin
               if (!acc.strobe[t11_bus_pkg::lane_lo])
                  hex_q[7:0] <= wview.d.lo;
               if (!acc.strobe[t11_bus_pkg::lane_hi])
                  hex_q[15:8] <= wview.d.hi;
            end
            default: ;                                 // Switches stay read-only
         endcase
      end
   end

   always_comb
   begin
      case (offs)
         board_pkg::reg_switches: acc.rdata_panel = {{PAD{1'b0}}, sw};
         board_pkg::reg_leds:     acc.rdata_panel = {{PAD{1'b0}}, led_q};
         board_pkg::reg_hex:      acc.rdata_panel = hex_q;
         default:                 acc.rdata_panel = '0;  // Spare word
      endcase
   end

   assign led  = led_q;
   assign hex0 = seg7(hex_q[3:0]);
   assign hex1 = seg7(hex_q[7:4]);
   assign hex2 = seg7(hex_q[11:8]);
   assign hex3 = seg7(hex_q[15:12]);

endmodule

//--- design/word_memory.sv
// Byte-lane word memory
`timescale 1ns/10ps

module word_memory #(
   parameter int MEM_WORDS = 256                       // Depth in words
)(
   input  logic clk,
   bus_if.target acc
);

   localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   t11_bus_pkg::ad_word_t  mem [MEM_WORDS];            // Storage
   t11_bus_pkg::ad_union_t wview;                      // Write word by lanes
   logic [AW-1:0]          idx;                        // Word index
   logic                   wr_en;                      // Write aimed here

   assign idx   = acc.addr.a.word_idx[AW-1:0];
   assign wview = acc.wdata;
   assign wr_en = acc.wr && (acc.sel == t11_bus_pkg::sel_mem);

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         if (!acc.strobe[t11_bus_pkg::lane_lo])
            mem[idx][7:0] <= wview.d.lo;               // Low lane
         if (!acc.strobe[t11_bus_pkg::lane_hi])
            mem[idx][15:8] <= wview.d.hi;              // High lane
      end
   end

   assign acc.rdata_mem = mem[idx];                    // Asynchronous read

endmodule

//--- design/bus_cycle_fsm.sv
// Bus cycle sequencer
`timescale 1ns/10ps

module bus_cycle_fsm #(
   parameter int MEM_WORDS   = 256,                    // Words decoded as memory
   parameter int WAIT_STATES = 1                       // Extra cycles before ready
)(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      init,             // Bus held off
   input  logic                      ras_n,            // Address strobe
   input  logic                      cas_n,            // Data strobe
   input  t11_bus_pkg::byte_strobe_t wb_n,             // Lane write mask
   input  t11_bus_pkg::ad_word_t     ad_in,            // Address or write data
   output t11_bus_pkg::ad_word_t     ad_out,           // Read data
   output logic                      ready,            // Cycle reply
   bus_if.master                     acc
);

   localparam int WW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   typedef enum logic [2:0] {
      st_idle,                                         // Waiting for RAS
      st_addr,                                         // Address held, waiting for CAS
      st_wait,                                         // Wait states running
      st_ready,                                        // Ready shown
      st_release                                       // CAS gone, RAS still low
   } state_t;

   state_t                   state;
   logic [WW-1:0]            wait_cnt;                 // Remaining wait states
   t11_bus_pkg::ad_union_t   ad_view;                  // ad_in as address
   logic [15:0]              word_num;                 // Full word number
   t11_bus_pkg::target_sel_t sel_dec;                  // Decoded target
   t11_bus_pkg::ad_word_t    rdata_mux;                // Selected read word

   assign ad_view  = ad_in;
   assign word_num = {1'b0, ad_view.a.region, ad_view.a.word_idx};

   // Address decode, panel wins over memory
   always_comb
   begin
      if (ad_in >= board_pkg::panel_base)
         sel_dec = t11_bus_pkg::sel_panel;
      else if (word_num < 16'(MEM_WORDS))
         sel_dec = t11_bus_pkg::sel_mem;
      else
         sel_dec = t11_bus_pkg::sel_none;               // Reads 0, writes dropped
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= st_idle;
         ready    <= 1'b0;
         acc.wr   <= 1'b0;
         acc.sel  <= t11_bus_pkg::sel_none;
         wait_cnt <= '0;
      end
      else
      begin
         acc.wr <= 1'b0;                               // Pulse lasts one cycle
         case (state)
            st_idle:
               if (!init && !ras_n)
               begin
                  acc.sel <= sel_dec;                  // Target fixed for the cycle
                  state   <= st_addr;
               end
            st_addr:
               if (!cas_n)
               begin
                  acc.wr   <= (wb_n != t11_bus_pkg::stb_read);
                  wait_cnt <= WW'(WAIT_STATES);
                  state    <= st_wait;
               end
               else if (ras_n)
                  state <= st_idle;                    // Aborted cycle
            st_wait:
               if (wait_cnt == '0)
               begin
                  ready <= 1'b1;
                  state <= st_ready;
               end
               else
                  wait_cnt <= wait_cnt - 1'b1;
            st_ready:
               if (cas_n)                              // Master saw ready
               begin
                  ready <= 1'b0;
                  state <= ras_n ? st_idle : st_release;
               end
            st_release:
               if (ras_n)
                  state <= st_idle;
            default:
               state <= st_idle;
         endcase
      end
   end

   // Payload captures
   always_ff @(posedge clk)
   begin
      if (state == st_idle && !ras_n)
         acc.addr <= ad_view;                          // Address on first RAS edge
      if (state == st_addr && !cas_n)
      begin
         acc.wdata  <= ad_in;                          // Data on first CAS edge
         acc.strobe <= wb_n;
      end
   end

   always_comb
   begin
      case (acc.sel)
         t11_bus_pkg::sel_mem:   rdata_mux = acc.rdata_mem;
         t11_bus_pkg::sel_panel: rdata_mux = acc.rdata_panel;
         default:                rdata_mux = '0;
      endcase
   end

   assign ad_out = ready ? rdata_mux : '0;             // Driven only with ready

endmodule

//--- design/reset_hold.sv
// Reset stretch counter
`timescale 1ns/10ps

module reset_hold #(
   parameter int HOLD_CYCLES = 16                      // Cycles after release
)(
   input  logic clk,
   input  logic rst_n,
   output logic init                                   // High while held
);

   localparam int CW = $clog2(HOLD_CYCLES + 1) > 0 ? $clog2(HOLD_CYCLES + 1) : 1;

   logic [CW-1:0] cnt;                                 // Cycles since release

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cnt  <= '0;
         init <= 1'b1;
      end
      else
      begin
         if (cnt != CW'(HOLD_CYCLES))
            cnt <= cnt + 1'b1;                         // Saturate at limit
         init <= (cnt != CW'(HOLD_CYCLES));            // One edge behind count
      end
   end

endmodule

//--- common/bus_if.sv
// Target access interface
`timescale 1ns/10ps

interface bus_if;

   t11_bus_pkg::target_sel_t  sel;                     // Latched target
   t11_bus_pkg::ad_union_t    addr;                    // Latched address
   t11_bus_pkg::ad_word_t     wdata;                   // Write data from CAS
   t11_bus_pkg::byte_strobe_t strobe;                  // Active-low lane mask
   logic                      wr;                      // One-cycle write pulse
   t11_bus_pkg::ad_word_t     rdata_mem;               // Memory read word
   t11_bus_pkg::ad_word_t     rdata_panel;             // Panel read word

   modport master (
      output sel, addr, wdata, strobe, wr,
      input  rdata_mem, rdata_panel
   );

   modport target (
      input  sel, addr, wdata, strobe, wr,
      output rdata_mem, rdata_panel
   );

endinterface

//--- common/board_pkg.sv
// Board memory map
package board_pkg;

   // Panel sits in the top 8 bytes
   localparam logic [15:0] panel_base = 16'hFFF8;      // First panel byte

   typedef logic [1:0] panel_reg_t;                    // Word offset inside panel

   localparam panel_reg_t reg_switches = 2'd0;         // Read-only switches
   localparam panel_reg_t reg_leds     = 2'd1;         // LED latch
   localparam panel_reg_t reg_hex      = 2'd2;         // Four hex digits

   localparam int seg_width = 7;                       // Segments g to a
   localparam int led_width = 10;                      // LEDs and switches

endpackage

//--- common/t11_bus_pkg.sv
// Multiplexed bus types
package t11_bus_pkg;

   typedef logic [15:0] ad_word_t;                     // One bus word

   // Address view of the bus word, valid during RAS
   typedef struct packed {
      logic [3:0]  region;                             // Upper address bits
      logic [10:0] word_idx;                           // Word index inside region
      logic        byte_sel;                           // Odd byte flag
   } ad_addr_t;

   // Data view of the bus word, valid during CAS
   typedef struct packed {
      logic [7:0] hi;                                  // High byte lane
      logic [7:0] lo;                                  // Low byte lane
   } ad_data_t;

   typedef union packed {
      ad_addr_t a;                                     // Seen as address
      ad_data_t d;                                     // Seen as data
   } ad_union_t;

   typedef logic [1:0] byte_strobe_t;                  // Active low, bit 0 is low lane

   localparam byte_strobe_t stb_read = 2'b11;          // No lane written
   localparam byte_strobe_t stb_word = 2'b00;          // Both lanes
   localparam byte_strobe_t stb_low  = 2'b10;          // Low byte only
   localparam byte_strobe_t stb_high = 2'b01;          // High byte only

   localparam int lane_lo = 0;                         // Strobe bit of low byte
   localparam int lane_hi = 1;                         // Strobe bit of high byte

   typedef enum logic [1:0] {
      sel_none  = 2'd0,                                // Unmapped
      sel_mem   = 2'd1,                                // Word memory
      sel_panel = 2'd2                                 // Front panel
   } target_sel_t;

endpackage
